// ==== ldpc_pkg.sv ====
// LDPC check-node shared definitions

package ldpc_pkg;

    // Check-node geometry
    localparam int EDGES     = 8;
    localparam int IDX_WIDTH = 3;
    localparam int MAG_WIDTH = 5;

    // Offset min-sum correction
    localparam int OFFSET = 1;

    // Pipeline depths in cycles
    localparam int SIGN_LATENCY = 3;
    localparam int CNU_LATENCY  = 4;

    // Sign-magnitude message, sign high means negative
    typedef struct packed {
        logic                 sign;
        logic [MAG_WIDTH-1:0] mag;
    } ldpc_msg_t;

    typedef ldpc_msg_t [EDGES-1:0] ldpc_vec_t;

    typedef enum logic {
        MODE_MIN_SUM = 1'b0,
        MODE_OFFSET  = 1'b1
    } cnu_mode_e;

    typedef struct packed {
        logic                 valid;
        cnu_mode_e            mode;
        logic [MAG_WIDTH-1:0] min1;
        logic [MAG_WIDTH-1:0] min2;
        logic [IDX_WIDTH-1:0] min_idx;
    } min_result_t;

    typedef struct packed {
        logic             total;
        logic [EDGES-1:0] own;
    } sign_result_t;

endpackage : ldpc_pkg

// ==== ldpc_signer.sv ====
// Check-node sign product
// Three-stage XOR tree with per-edge signs delayed alongside

`timescale 1ns/1ps

module ldpc_signer import ldpc_pkg::*; (
    input  logic         i_clock,
    input  logic         i_reset,
    input  ldpc_vec_t    i_msgs,
    output sign_result_t o_signs
);

    logic [EDGES-1:0] edge_signs;

    logic sign_lo_r0;
    logic sign_hi_r0;
    logic sign_all_r1;
    logic sign_all_r2;

    // Own signs, one entry per stage
    logic [EDGES-1:0] own_pipe [SIGN_LATENCY];

    always_comb begin
        for (int k = 0; k < EDGES; k++) begin
            edge_signs[k] = i_msgs[k].sign;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            sign_lo_r0  <= 1'b0;
            sign_hi_r0  <= 1'b0;
            sign_all_r1 <= 1'b0;
            sign_all_r2 <= 1'b0;
            for (int s = 0; s < SIGN_LATENCY; s++) begin
                own_pipe[s] <= '0;
            end
        end else begin
            // Stage 0, two half products
            sign_lo_r0  <= ^edge_signs[3:0];
            sign_hi_r0  <= ^edge_signs[7:4];
            // Stage 1
            sign_all_r1 <= sign_lo_r0 ^ sign_hi_r0;
            // Stage 2
            sign_all_r2 <= sign_all_r1;

            own_pipe[0] <= edge_signs;
            for (int s = 1; s < SIGN_LATENCY; s++) begin
                own_pipe[s] <= own_pipe[s-1];
            end
        end
    end

    assign o_signs.total = sign_all_r2;
    assign o_signs.own   = own_pipe[SIGN_LATENCY-1];

endmodule : ldpc_signer

// ==== ldpc_minimum.sv ====
// Check-node minimum search
// Three-stage min1, min2 and min-index tree

`timescale 1ns/1ps

module ldpc_minimum import ldpc_pkg::*; (
    input  logic        i_clock,
    input  logic        i_reset,
    input  logic        i_valid,
    input  cnu_mode_e   i_mode,
    input  ldpc_vec_t   i_msgs,
    output min_result_t o_min
);

    // Partial result of one subtree
    typedef struct packed {
        logic [MAG_WIDTH-1:0] min1;
        logic [MAG_WIDTH-1:0] min2;
        logic [IDX_WIDTH-1:0] idx;
    } min_part_t;

    // Leaf compare of two neighbouring edges, lower index wins ties
    function automatic min_part_t pair_min(input ldpc_msg_t a, input ldpc_msg_t b,
                                           input int a_idx);
        min_part_t p;
        if (b.mag < a.mag) begin
            p.min1 = b.mag;
            p.min2 = a.mag;
            p.idx  = IDX_WIDTH'(a_idx + 1);
        end else begin
            p.min1 = a.mag;
            p.min2 = b.mag;
            p.idx  = IDX_WIDTH'(a_idx);
        end
        return p;
    endfunction

    // Merge of two subtrees, a covers the lower indices
    function automatic min_part_t merge_min(input min_part_t a, input min_part_t b);
        min_part_t m;
        if (b.min1 < a.min1) begin
            m.min1 = b.min1;
            m.idx  = b.idx;
            m.min2 = (a.min1 < b.min2) ? a.min1 : b.min2;
        end else begin
            m.min1 = a.min1;
            m.idx  = a.idx;
            m.min2 = (b.min1 < a.min2) ? b.min1 : a.min2;
        end
        return m;
    endfunction

    min_part_t pair_r0 [4];
    min_part_t quad_r1 [2];
    min_part_t root_c;

    logic      valid_r0;
    logic      valid_r1;
    cnu_mode_e mode_r0;
    cnu_mode_e mode_r1;

    // Final merge ahead of the result register
    always_comb begin
        root_c = merge_min(quad_r1[0], quad_r1[1]);
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int j = 0; j < 4; j++) begin
                pair_r0[j] <= '0;
            end
            quad_r1[0] <= '0;
            quad_r1[1] <= '0;
            valid_r0   <= 1'b0;
            valid_r1   <= 1'b0;
            mode_r0    <= MODE_MIN_SUM;
            mode_r1    <= MODE_MIN_SUM;
            o_min      <= '0;
        end else begin
            // Stage 0
            for (int j = 0; j < 4; j++) begin
                pair_r0[j] <= pair_min(i_msgs[2*j], i_msgs[2*j+1], 2*j);
            end
            valid_r0 <= i_valid;
            mode_r0  <= i_mode;

            // Stage 1
            quad_r1[0] <= merge_min(pair_r0[0], pair_r0[1]);
            quad_r1[1] <= merge_min(pair_r0[2], pair_r0[3]);
            valid_r1   <= valid_r0;
            mode_r1    <= mode_r0;

            // Stage 2, final merge into the result
            o_min.min1    <= root_c.min1;
            o_min.min2    <= root_c.min2;
            o_min.min_idx <= root_c.idx;
            o_min.valid   <= valid_r1;
            o_min.mode    <= mode_r1;
        end
    end

endmodule : ldpc_minimum

// ==== ldpc_check_update.sv ====
// Check-to-variable message update
// Excluded-edge magnitude and sign, optional offset

`timescale 1ns/1ps

module ldpc_check_update import ldpc_pkg::*; (
    input  logic         i_clock,
    input  logic         i_reset,
    input  sign_result_t i_signs,
    input  min_result_t  i_min,
    output logic         o_valid,
    output ldpc_vec_t    o_msgs
);

    localparam logic [MAG_WIDTH-1:0] OFFSET_MAG = MAG_WIDTH'(OFFSET);

    logic [MAG_WIDTH-1:0] mag_sel [EDGES];
    ldpc_vec_t            msgs_next;

    always_comb begin
        for (int k = 0; k < EDGES; k++) begin
            // The minimum edge sees the second minimum
            if (IDX_WIDTH'(k) == i_min.min_idx) begin
                mag_sel[k] = i_min.min2;
            end else begin
                mag_sel[k] = i_min.min1;
            end

            if (i_min.mode == MODE_OFFSET) begin
                // Saturate at zero
                if (mag_sel[k] > OFFSET_MAG) begin
                    msgs_next[k].mag = mag_sel[k] - OFFSET_MAG;
                end else begin
                    msgs_next[k].mag = '0;
                end
            end else begin
                msgs_next[k].mag = mag_sel[k];
            end

            // Product of the other seven signs
            msgs_next[k].sign = i_signs.total ^ i_signs.own[k];
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_valid <= 1'b0;
            o_msgs  <= '0;
        end else begin
            o_valid <= i_min.valid;
            o_msgs  <= msgs_next;
        end
    end

endmodule : ldpc_check_update

// ==== ldpc_check_node.sv ====
// Min-sum LDPC check-node unit
// Four-cycle pipeline, one vector per cycle

`timescale 1ns/1ps

module ldpc_check_node import ldpc_pkg::*; (
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_valid,
    input  cnu_mode_e i_mode,
    input  ldpc_vec_t i_msgs,
    output logic      o_valid,
    output ldpc_vec_t o_msgs
);

    // Both results land on the same cycle
    sign_result_t signs;
    min_result_t  mins;

    ldpc_signer u_signer (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_msgs  (i_msgs),
        .o_signs (signs)
    );

    ldpc_minimum u_minimum (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_mode  (i_mode),
        .i_msgs  (i_msgs),
        .o_min   (mins)
    );

    ldpc_check_update u_update (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_signs (signs),
        .i_min   (mins),
        .o_valid (o_valid),
        .o_msgs  (o_msgs)
    );

endmodule : ldpc_check_node

// ==== tb_check_node.sv ====
// Testbench for the LDPC check-node unit

`timescale 1ns/1ps

module tb_check_node import ldpc_pkg::*; ();

    localparam int NUM_TESTS      = 6;
    localparam int NUM_VECTORS    = 284;
    localparam int TIMEOUT_CYCLES = 40 * NUM_VECTORS + 100;
    localparam logic [31:0] SEED  = 32'h04f4e922;
    localparam logic [MAG_WIDTH-1:0] OFFSET_MAG = MAG_WIDTH'(OFFSET);

    localparam int T_RESET  = 0;
    localparam int T_RANDOM = 1;
    localparam int T_SIGN   = 2;
    localparam int T_TIES   = 3;
    localparam int T_OFFSET = 4;
    localparam int T_GAPPED = 5;

    typedef struct packed {
        ldpc_vec_t msgs;
        int        cycle;
        int        test_id;
    } exp_entry_t;

    logic      i_clock = 1'b0;
    logic      i_reset;
    logic      i_valid = 1'b0;
    cnu_mode_e i_mode;
    ldpc_vec_t i_msgs;
    logic      o_valid;
    ldpc_vec_t o_msgs;

    logic [31:0] lfsr_state;
    exp_entry_t  exp_q [$];
    int          cycle_count = 0;
    int          current_test = T_RESET;
    int          checks = 0;
    int          test_errors [NUM_TESTS];
    int          test_vectors [NUM_TESTS];

    ldpc_check_node dut (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_valid (i_valid),
        .i_mode  (i_mode),
        .i_msgs  (i_msgs),
        .o_valid (o_valid),
        .o_msgs  (o_msgs)
    );

    always #2 i_clock = ~i_clock;

    function automatic string test_name(input int id);
        case (id)
            T_RESET:  return "reset";
            T_RANDOM: return "min_sum_random";
            T_SIGN:   return "sign_rule";
            T_TIES:   return "ties_extremes";
            T_OFFSET: return "offset_mode";
            default:  return "gapped_strobes";
        endcase
    endfunction

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < count; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    task automatic random_vector(output ldpc_vec_t v);
        logic [31:0] bits;
        for (int k = 0; k < EDGES; k++) begin
            take_bits(1, bits);
            v[k].sign = bits[0];
            take_bits(MAG_WIDTH, bits);
            v[k].mag = bits[MAG_WIDTH-1:0];
        end
    endtask

    function automatic ldpc_vec_t fill_vector(input logic [MAG_WIDTH-1:0] mag,
                                              input logic [EDGES-1:0] signs);
        ldpc_vec_t v;
        for (int k = 0; k < EDGES; k++) begin
            v[k].sign = signs[k];
            v[k].mag  = mag;
        end
        return v;
    endfunction

    // Each outgoing message uses only the other seven edges
    function automatic ldpc_vec_t expected_msgs(input ldpc_vec_t v, input cnu_mode_e mode);
        ldpc_vec_t            r;
        logic [MAG_WIDTH-1:0] m;
        logic                 s;
        for (int k = 0; k < EDGES; k++) begin
            m = '1;
            s = 1'b0;
            for (int j = 0; j < EDGES; j++) begin
                if (j != k) begin
                    s = s ^ v[j].sign;
                    if (v[j].mag < m) begin
                        m = v[j].mag;
                    end
                end
            end
            if (mode == MODE_OFFSET) begin
                m = (m > OFFSET_MAG) ? m - OFFSET_MAG : '0;
            end
            r[k].sign = s;
            r[k].mag  = m;
        end
        return r;
    endfunction

    task automatic send_vector(input ldpc_vec_t msgs, input cnu_mode_e mode);
        exp_entry_t e;
        @(negedge i_clock);
        i_valid = 1'b1;
        i_mode  = mode;
        i_msgs  = msgs;
        e.msgs    = expected_msgs(msgs, mode);
        e.cycle   = cycle_count;
        e.test_id = current_test;
        exp_q.push_back(e);
        test_vectors[current_test]++;
    endtask

    // Junk data without a strobe must be ignored
    task automatic idle_cycles(input int n);
        ldpc_vec_t junk;
        for (int i = 0; i < n; i++) begin
            @(negedge i_clock);
            random_vector(junk);
            i_valid = 1'b0;
            i_msgs  = junk;
        end
    endtask

    task automatic check_valid_low();
        assert (o_valid == 1'b0) else begin
            $display("CHECK FAILED test %s: o_valid expected 0 actual %b",
                     test_name(current_test), o_valid);
            test_errors[current_test]++;
        end
    endtask

    task automatic finish_test();
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(3);
        $display("test %-15s %4d vectors, %0d errors", test_name(current_test),
                 test_vectors[current_test], test_errors[current_test]);
    endtask

    // Output check against the queue head, plus latency and order
    always @(posedge i_clock) begin
        exp_entry_t head;
        if (!i_reset && o_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected o_valid pulse with no vector pending in test %s",
                         test_name(current_test));
                test_errors[current_test]++;
            end else begin
                head = exp_q.pop_front();
                checks++;
                assert (o_msgs == head.msgs) else begin
                    $display("CHECK FAILED test %s: expected %h actual %h",
                             test_name(head.test_id), head.msgs, o_msgs);
                    test_errors[head.test_id]++;
                end
                assert (cycle_count - head.cycle == CNU_LATENCY) else begin
                    $display("CHECK FAILED test %s: expected latency %0d actual %0d",
                             test_name(head.test_id), CNU_LATENCY,
                             cycle_count - head.cycle);
                    test_errors[head.test_id]++;
                end
            end
        end
        cycle_count++;
    end

    strobe_latency: assert property (@(posedge i_clock) disable iff (i_reset)
        o_valid == $past(i_valid, CNU_LATENCY))
    else begin
        $display("o_valid did not follow the input strobe by %0d cycles in test %s",
                 CNU_LATENCY, test_name(current_test));
        test_errors[current_test]++;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Run aborted after %0d cycles without finishing the tests", cycle_count);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        ldpc_vec_t   v;
        logic [31:0] bits;
        int          total_errors;
        lfsr_state = SEED;
        i_reset    = 1'b1;
        i_valid    = 1'b0;
        i_mode     = MODE_MIN_SUM;
        i_msgs     = '0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_errors[t]  = 0;
            test_vectors[t] = 0;
        end

        current_test = T_RESET;
        repeat (2) begin
            @(negedge i_clock);
            check_valid_low();
        end
        i_reset = 1'b0;
        for (int i = 0; i < 6; i++) begin
            idle_cycles(1);
            check_valid_low();
        end
        finish_test();

        current_test = T_RANDOM;
        for (int i = 0; i < 200; i++) begin
            random_vector(v);
            send_vector(v, MODE_MIN_SUM);
        end
        finish_test();

        // Zero, one, seven and eight negative edges
        current_test = T_SIGN;
        foreach (v[k]) v[k].mag = MAG_WIDTH'(k + 3);
        for (int i = 0; i < EDGES; i++) v[i].sign = 1'b0;
        send_vector(v, MODE_MIN_SUM);
        v[2].sign = 1'b1;
        send_vector(v, MODE_MIN_SUM);
        for (int i = 0; i < EDGES; i++) v[i].sign = (i != 5);
        send_vector(v, MODE_MIN_SUM);
        v[5].sign = 1'b1;
        send_vector(v, MODE_MIN_SUM);
        finish_test();

        current_test = T_TIES;
        v = fill_vector(5'd10, 8'h96);
        v[2].mag = 5'd3;
        v[5].mag = 5'd3;
        send_vector(v, MODE_MIN_SUM);
        send_vector(fill_vector(5'd7, 8'h0f), MODE_MIN_SUM);
        v = fill_vector(5'd9, 8'h21);
        v[6].mag = 5'd0;
        v[1].mag = 5'd4;
        send_vector(v, MODE_MIN_SUM);
        send_vector(fill_vector('1, 8'hc3), MODE_MIN_SUM);
        finish_test();

        // Minima of 0, 1 and 2, each in both modes
        current_test = T_OFFSET;
        v = fill_vector(5'd20, 8'h5a);
        v[3].mag = 5'd0;
        v[6].mag = 5'd1;
        send_vector(v, MODE_OFFSET);
        send_vector(v, MODE_MIN_SUM);
        v = fill_vector(5'd15, 8'h81);
        v[0].mag = 5'd1;
        v[7].mag = 5'd2;
        send_vector(v, MODE_OFFSET);
        send_vector(v, MODE_MIN_SUM);
        v = fill_vector(5'd9, 8'h3c);
        v[5].mag = 5'd2;
        v[2].mag = 5'd5;
        send_vector(v, MODE_OFFSET);
        send_vector(v, MODE_MIN_SUM);
        for (int i = 0; i < 30; i++) begin
            random_vector(v);
            send_vector(v, (i % 2 == 0) ? MODE_OFFSET : MODE_MIN_SUM);
        end
        finish_test();

        current_test = T_GAPPED;
        for (int i = 0; i < 40; i++) begin
            random_vector(v);
            take_bits(1, bits);
            send_vector(v, cnu_mode_e'(bits[0]));
            take_bits(2, bits);
            idle_cycles(int'(bits[1:0]));
        end
        finish_test();

        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total_errors += test_errors[t];
        end
        $display("tests: %0d, checks: %0d, pending: %0d, errors: %0d",
                 NUM_TESTS, checks, exp_q.size(), total_errors);
        if (total_errors == 0 && exp_q.size() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule : tb_check_node

// ==== build.f ====
ldpc_pkg.sv
ldpc_signer.sv
ldpc_minimum.sv
ldpc_check_update.sv
ldpc_check_node.sv
tb_check_node.sv

// ==== Makefile ====
# Verilator build and run for the LDPC check-node unit

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing
TOP       := tb_check_node
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := SIMULATION PASSED

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
